// ==== Bender.yml ====
package:
  name: rhd_link

sources:
  - files:
      - logic/rhd_pkg.sv
      - logic/cmd_parser.sv
      - logic/rhd_ctrl.sv
      - logic/spi_master.sv
      - logic/rsp_tx.sv
      - logic/rhd_link_top.sv
  - target: simulation
    files:
      - tb/rhd_spi_model.sv
      - tb/tb_rhd_link.sv

// ==== logic/cmd_parser.sv ====
// command parser: collects stream bytes into frames and hands out rx credits
`timescale 1ns/1ps

module cmd_parser
  import rhd_pkg::*;
(
  input  logic       clk_125m,
  input  logic       arst_n,
  input  byte_beat_t rx,
  input  logic       cmd_ready,
  output cmd_t       cmd,
  output logic       cmd_valid,
  output logic       rx_credit
);

  localparam int CW = $clog2(FRAME_BYTES + 1);

  logic [1:0]    byte_cnt;
  logic [CW-1:0] pend_cnt; // credits still to be pulsed out
  logic [CW-1:0] out_cnt;  // credits granted and not yet used
  logic          accept;

  assign accept = cmd_valid && cmd_ready;

  // frame shift register, first byte ends up in op
  always_ff @(posedge clk_125m) begin
    if (rx.val) cmd <= cmd_t'({cmd[15:0], rx.dat});
  end

  always_ff @(posedge clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      byte_cnt  <= '0;
      cmd_valid <= 1'b0;
      pend_cnt  <= CW'(FRAME_BYTES); // initial window
      out_cnt   <= '0;
      rx_credit <= 1'b0;
    end else begin
      if (rx.val) begin
        if (byte_cnt == 2'(FRAME_BYTES - 1)) begin
          byte_cnt  <= '0;
          cmd_valid <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end else if (accept) begin
        cmd_valid <= 1'b0;
      end

      // one credit pulse per cycle, refill on accept
      rx_credit <= (pend_cnt != '0);
      if (accept) pend_cnt <= CW'(FRAME_BYTES);
      else if (pend_cnt != '0) pend_cnt <= pend_cnt - 1'b1;

      if (rx_credit && !rx.val) out_cnt <= out_cnt + 1'b1;
      else if (!rx_credit && rx.val) out_cnt <= out_cnt - 1'b1;
    end
  end

  // sender must stay inside the granted window
  a_rx_in_window: assert property (@(posedge clk_125m) disable iff (!arst_n)
    rx.val |-> out_cnt != '0)
    else $error("rx byte without outstanding credit");

endmodule

// ==== logic/rhd_ctrl.sv ====
// command controller that runs each command as spi words and builds the response
`timescale 1ns/1ps

module rhd_ctrl
  import rhd_pkg::*;
(
  input  logic        clk_125m,
  input  logic        arst_n,
  input  cmd_t        cmd,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  output logic [15:0] spi_word,
  output logic        spi_start,
  input  logic [15:0] spi_rdata,
  input  logic        spi_done,
  output rsp_t        rsp,
  output logic        rsp_valid,
  input  logic        rsp_ready
);

  localparam logic [15:0] DUMMY_WORD = {2'b11, 6'(ID_REG), 8'h00}; // id register read

  ctrl_state_e state;
  logic        cmd_ok;   // known opcode and argument in range
  logic [15:0] cmd_word;
  logic        spi_busy; // a word is on the wire

  assign cmd_ready  = (state == S_IDLE);
  assign rsp_valid  = (state == S_RESP);

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    cmd_ok   = (cmd.arg <= 8'(ID_REG));
    cmd_word = '0;
    case (cmd.op)
      OP_WRITE:   cmd_word = {2'b10, cmd.arg[5:0], cmd.data};
      OP_READ:    cmd_word = {2'b11, cmd.arg[5:0], 8'h00};
      OP_CONVERT: cmd_word = {2'b00, cmd.arg[5:0], 8'h00};
      default:    cmd_ok   = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      state     <= S_IDLE;
      spi_start <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      case (state)
        S_IDLE: if (cmd_valid) begin
          if (cmd_ok) begin
            spi_start <= 1'b1;
            state     <= S_CMD;
          end else begin
            state <= S_RESP; // no spi traffic for errors
          end
        end
        S_CMD: if (spi_done) begin
          spi_start <= 1'b1;
          state     <= S_DUMMY1;
        end
        S_DUMMY1: if (spi_done) begin
          spi_start <= 1'b1;
          state     <= S_DUMMY2;
        end
        S_DUMMY2: if (spi_done) state <= S_RESP;
        S_RESP:   if (rsp_ready) state <= S_IDLE;
        default:  state <= S_IDLE;
      endcase
    end
  end

  // word and response payload
  always_ff @(posedge clk_125m) begin
    if (state == S_IDLE && cmd_valid) begin
      spi_word   <= cmd_ok ? cmd_word : spi_word;
      rsp.status <= cmd_ok ? cmd.op : {1'b1, cmd.op[6:0]};
      rsp.result <= '0;
    end else if (spi_done && (state == S_CMD || state == S_DUMMY1)) begin
      spi_word <= DUMMY_WORD;
    end else if (spi_done && state == S_DUMMY2) begin
      rsp.result <= spi_rdata; // result of the command word
    end
  end

  always_ff @(posedge clk_125m or negedge arst_n) begin
    if (!arst_n) spi_busy <= 1'b0;
    else if (spi_start) spi_busy <= 1'b1;
    else if (spi_done) spi_busy <= 1'b0;
  end

  // one word at a time between start and done
  a_spi_one_word: assert property (@(posedge clk_125m) disable iff (!arst_n)
    spi_start |-> !spi_busy)
    else $error("spi_start while a word is outstanding");

endmodule

// ==== logic/rhd_link_top.sv ====
// rhd link top: command stream in, spi to the amplifier, response stream out
`timescale 1ns/1ps

module rhd_link_top
  import rhd_pkg::*;
#(
  parameter int CLK_DIV       = 4,
  parameter int TX_CREDIT_MAX = 16
) (
  input  logic       clk_125m,
  input  logic       arst_n,
  input  byte_beat_t rx,        // from the tcp stack
  output logic       rx_credit,
  output byte_beat_t tx,        // to the tcp stack
  input  logic       tx_credit,
  output logic       cs_n,
  output logic       sclk,
  output logic       mosi,
  input  logic       miso
);

  cmd_t        cmd;
  logic        cmd_valid, cmd_ready;
  logic [15:0] spi_word, spi_rdata;
  logic        spi_start, spi_done;
  rsp_t        rsp;
  logic        rsp_valid, rsp_ready;

  ////////////////////////////////////////////////////////////////////////////
  // receive side
  ////////////////////////////////////////////////////////////////////////////

  cmd_parser parser0 (
    .clk_125m, .arst_n,
    .rx        (rx),
    .cmd_ready (cmd_ready),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .rx_credit (rx_credit)
  );

  rhd_ctrl ctrl0 (
    .clk_125m, .arst_n,
    .cmd, .cmd_valid, .cmd_ready,
    .spi_word, .spi_start, .spi_rdata, .spi_done,
    .rsp, .rsp_valid, .rsp_ready
  );

  ////////////////////////////////////////////////////////////////////////////
  // amplifier and transmit side
  ////////////////////////////////////////////////////////////////////////////

  spi_master #(.CLK_DIV(CLK_DIV)) spi0 (
    .clk_125m, .arst_n,
    .spi_word, .spi_start, .spi_rdata, .spi_done,
    .cs_n, .sclk, .mosi, .miso
  );

  rsp_tx #(.TX_CREDIT_MAX(TX_CREDIT_MAX)) tx0 (
    .clk_125m, .arst_n,
    .rsp, .rsp_valid, .rsp_ready,
    .tx_credit (tx_credit),
    .tx        (tx)
  );

endmodule

// ==== logic/rhd_pkg.sv ====
// rhd link shared types: opcodes, controller states, frame and byte structs

package rhd_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int FRAME_BYTES = 3;   // command and response frame length
  localparam int ID_REG      = 63;  // read-only id register, used for dummies

  ////////////////////////////////////////////////////////////////////////////
  // enums
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [7:0] {
    OP_WRITE   = 8'h01,
    OP_READ    = 8'h02,
    OP_CONVERT = 8'h03
  } op_e;

  typedef enum logic [2:0] {
    S_IDLE,   // waiting for a command frame
    S_CMD,    // command word on the wire
    S_DUMMY1, // first id read
    S_DUMMY2, // second id read, carries the result
    S_RESP    // response held for the transmitter
  } ctrl_state_e;

  ////////////////////////////////////////////////////////////////////////////
  // frame structs
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [7:0] op;   // raw opcode byte, may be invalid
    logic [7:0] arg;  // register address or channel
    logic [7:0] data;
  } cmd_t;

  typedef struct packed {
    logic [7:0]  status; // echoed opcode, bit 7 flags an error
    logic [15:0] result;
  } rsp_t;

  typedef struct packed {
    logic [7:0] dat;
    logic       val;
  } byte_beat_t;

endpackage

// ==== logic/rsp_tx.sv ====
// response transmitter: sends response frames byte by byte against tx credits
`timescale 1ns/1ps

module rsp_tx
  import rhd_pkg::*;
#(
  parameter int TX_CREDIT_MAX = 16
) (
  input  logic       clk_125m,
  input  logic       arst_n,
  input  rsp_t       rsp,
  input  logic       rsp_valid,
  output logic       rsp_ready,
  input  logic       tx_credit,
  output byte_beat_t tx
);

  localparam int CW = $clog2(TX_CREDIT_MAX + 1);

  rsp_t          frame;
  logic          full;
  logic [1:0]    idx;      // next byte, status first
  logic [CW-1:0] cred_cnt;
  logic          emit;

  assign rsp_ready = !full;
  assign emit      = full && (cred_cnt != '0);

  always_comb begin
    tx.val = emit;
    tx.dat = frame[8 * (FRAME_BYTES - 1 - idx) +: 8];
  end

  always_ff @(posedge clk_125m) begin
    if (rsp_valid && rsp_ready) frame <= rsp;
  end

  always_ff @(posedge clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      full     <= 1'b0;
      idx      <= '0;
      cred_cnt <= '0;
    end else begin
      if (rsp_valid && rsp_ready) begin
        full <= 1'b1;
        idx  <= '0;
      end else if (emit) begin
        if (idx == 2'(FRAME_BYTES - 1)) full <= 1'b0;
        idx <= idx + 1'b1;
      end

      // saturating credit count
      if (tx_credit && !emit && cred_cnt != CW'(TX_CREDIT_MAX)) cred_cnt <= cred_cnt + 1'b1;
      else if (emit && !tx_credit) cred_cnt <= cred_cnt - 1'b1;
    end
  end

  // a byte spends a credit held from an earlier cycle
  a_tx_credit: assert property (@(posedge clk_125m) disable iff (!arst_n)
    tx.val |-> ($past(cred_cnt) != '0) || $past(tx_credit))
    else $error("tx byte without credit");

endmodule

// ==== logic/spi_master.sv ====
// spi master: 16-bit mode 0 word transfers with clock divider and cs_n gap
`timescale 1ns/1ps

module spi_master #(
  parameter int CLK_DIV = 4  // system cycles per sclk half period
) (
  input  logic        clk_125m,
  input  logic        arst_n,
  input  logic [15:0] spi_word,
  input  logic        spi_start,
  output logic [15:0] spi_rdata,
  output logic        spi_done,
  output logic        cs_n,
  output logic        sclk,
  output logic        mosi,
  input  logic        miso
);

  localparam int DIV_W = $clog2(2 * CLK_DIV);

  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_GAP} spi_state_e;

  spi_state_e       state;
  logic [DIV_W-1:0] div_cnt;
  logic [3:0]       bit_cnt;
  logic             start_pend; // start seen during the cs_n gap
  logic [15:0]      tx_sh;
  logic [15:0]      rx_sh;
  logic             half_end;

  assign half_end = (state == SPI_SHIFT) && (div_cnt == DIV_W'(CLK_DIV - 1));
  assign mosi     = tx_sh[15]; // msb first

  always_ff @(posedge clk_125m or negedge arst_n) begin
    if (!arst_n) begin
      state      <= SPI_IDLE;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      start_pend <= 1'b0;
      cs_n       <= 1'b1;
      sclk       <= 1'b0;
      spi_done   <= 1'b0;
    end else begin
      spi_done <= 1'b0;
      case (state)
        SPI_IDLE: if (spi_start) begin
          state   <= SPI_SHIFT;
          cs_n    <= 1'b0;
          div_cnt <= '0;
          bit_cnt <= '0;
        end
        SPI_SHIFT: begin
          if (half_end) begin
            div_cnt <= '0;
            sclk    <= ~sclk;
            if (sclk) begin // falling edge closes a bit
              bit_cnt <= bit_cnt + 1'b1;
              if (bit_cnt == 4'd15) begin
                state <= SPI_GAP;
                cs_n  <= 1'b1;
              end
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        SPI_GAP: begin
          if (div_cnt == '0) spi_done <= 1'b1;
          if (spi_start) start_pend <= 1'b1;
          if (div_cnt == DIV_W'(2 * CLK_DIV - 1)) begin
            div_cnt <= '0;
            if (start_pend || spi_start) begin
              state      <= SPI_SHIFT;
              cs_n       <= 1'b0;
              bit_cnt    <= '0;
              start_pend <= 1'b0;
            end else begin
              state <= SPI_IDLE;
            end
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  // shift on falling, sample on rising
  always_ff @(posedge clk_125m) begin
    if (spi_start) tx_sh <= spi_word;
    else if (half_end && sclk) tx_sh <= {tx_sh[14:0], 1'b0};
    if (half_end && !sclk) rx_sh <= {rx_sh[14:0], miso};
    if (state == SPI_GAP && div_cnt == '0) spi_rdata <= rx_sh;
  end

  a_sclk_in_frame: assert property (@(posedge clk_125m) disable iff (!arst_n)
    !$stable(sclk) |-> $past(!cs_n))
    else $error("sclk toggled with cs_n high");

endmodule

// ==== rhd_link.f ====
logic/rhd_pkg.sv
logic/cmd_parser.sv
logic/rhd_ctrl.sv
logic/spi_master.sv
logic/rsp_tx.sv
logic/rhd_link_top.sv
tb/rhd_spi_model.sv
tb/tb_rhd_link.sv

// ==== tb/rhd_spi_model.sv ====
// behavioral rhd2000-style amplifier: register file and two-word result pipeline
`timescale 1ns/1ps

module rhd_spi_model (
  input  logic cs_n,
  input  logic sclk,
  input  logic mosi,
  output logic miso,
  output int   words  // cs_n falling edges seen
);

  logic [7:0]  regs [0:63];
  logic [15:0] in_sh;
  logic [15:0] out_sh;
  logic [15:0] pipe0;  // result of the last word
  logic [15:0] pipe1;  // result of the word before, goes out next
  logic [15:0] res;
  int          nbits;

  initial begin
    for (int i = 0; i < 64; i++) regs[i] = 8'(i) ^ 8'hA5;
    miso  = 1'b0;
    pipe0 = '0;
    pipe1 = '0;
    words = 0;
    nbits = 0;
  end

  always @(negedge cs_n) begin
    words  = words + 1;
    nbits  = 0;
    out_sh = pipe1;
    miso  <= pipe1[15];
  end

  // mode 0, chip shifts on the falling edge
  always @(negedge sclk) begin
    if (!cs_n) begin
      out_sh = {out_sh[14:0], 1'b0};
      miso  <= out_sh[15];
    end
  end

  always @(posedge sclk) begin
    in_sh = {in_sh[14:0], mosi};
    nbits = nbits + 1;
  end

  // decode a complete word and push its answer
  always @(posedge cs_n) begin
    if (nbits == 16) begin
      case (in_sh[15:14])
        2'b10: begin
          res = {8'hFF, in_sh[7:0]};
          if (in_sh[13:8] != 6'd63) regs[in_sh[13:8]] = in_sh[7:0];
        end
        2'b11:   res = {8'h00, (in_sh[13:8] == 6'd63) ? 8'h01 : regs[in_sh[13:8]]};
        2'b00:   res = 16'h8000 + 16'(in_sh[13:8]) * 16'd257;
        default: res = 16'h0000;
      endcase
      pipe1 = pipe0;
      pipe0 = res;
    end
  end

endmodule

// ==== tb/tb_rhd_link.sv ====
// testbench for the rhd link driving command frames against a model amplifier on spi
`timescale 1ns/1ps

module tb_rhd_link
  import rhd_pkg::*;
();

  localparam int          CLK_DIV  = 2;
  localparam int          WAIT_MAX = 2000;  // cycles before a wait gives up
  localparam logic [31:0] SEED     = 32'hc884f502;

  logic        clk_125m;
  logic        arst_n;
  byte_beat_t  rx;
  byte_beat_t  tx;
  logic        rx_credit;
  logic        tx_credit;
  logic        cs_n, sclk, mosi, miso;
  int          cs_words;

  logic [7:0]  rx_q[$];       // bytes waiting for an rx credit
  logic [7:0]  tx_q[$];       // bytes collected from the dut
  int          rx_avail;      // sender's unused credits
  int          rx_cred_total;
  int          tx_budget;     // tx credits still to grant
  int          frames_sent;
  int          init_credits;
  logic [31:0] gap_state;
  logic [31:0] data_state;
  int          err_cnt;
  int          test_err;
  int          tests_run;
  int          tests_bad;

  rhd_link_top #(.CLK_DIV(CLK_DIV), .TX_CREDIT_MAX(16)) dut0 (
    .clk_125m, .arst_n, .rx, .rx_credit, .tx, .tx_credit,
    .cs_n, .sclk, .mosi, .miso
  );

  rhd_spi_model model0 (.cs_n, .sclk, .mosi, .miso, .words(cs_words));

  always #4 clk_125m = ~clk_125m;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // stream drivers
  ////////////////////////////////////////////////////////////////////////////

  // sender spends only credits it has counted
  always @(posedge clk_125m) begin
    if (rx_credit) begin
      rx_avail      = rx_avail + 1;
      rx_cred_total = rx_cred_total + 1;
    end
    if (rx_q.size() > 0 && rx_avail > 0) begin
      rx.dat  <= rx_q.pop_front();
      rx.val  <= 1'b1;
      rx_avail = rx_avail - 1;
    end else begin
      rx.val <= 1'b0;
    end
  end

  always @(posedge clk_125m) begin
    gap_state = lcg_next(gap_state);
    if (arst_n && tx_budget > 0 && gap_state[17:16] != 2'b00) begin
      tx_credit <= 1'b1;  // random gaps between grants
      tx_budget  = tx_budget - 1;
    end else begin
      tx_credit <= 1'b0;
    end
  end

  always @(posedge clk_125m) begin
    if (arst_n && tx.val) tx_q.push_back(tx.dat);
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_timeout(input string what);
    $display("timeout: %s did not finish within %0d cycles", what, WAIT_MAX);
    err_cnt++;
  endtask

  task automatic check_rsp(input string what, input logic [7:0] st, input logic [15:0] res,
                           input logic [7:0] exp_st, input logic [15:0] exp_res);
    assert (st === exp_st && res === exp_res)
      else begin
        $display("Error at %0t ns: %s got %h/%h, expected %h/%h",
                 $time, what, st, res, exp_st, exp_res);
        err_cnt++;
      end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp)
      else begin
        $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        err_cnt++;
      end
  endtask

  task automatic grant_tx(input int n);
    @(negedge clk_125m);
    tx_budget += n;
  endtask

  task automatic send_frame(input logic [7:0] op, arg, dat);
    int n;
    @(negedge clk_125m);
    rx_q.push_back(op);
    rx_q.push_back(arg);
    rx_q.push_back(dat);
    frames_sent++;
    n = 0;
    while (rx_q.size() != 0 && n < WAIT_MAX) begin
      @(negedge clk_125m);
      n++;
    end
    if (rx_q.size() != 0) report_timeout("sending a command frame");
  endtask

  task automatic recv_frame(output logic [7:0] st, output logic [15:0] res);
    int n;
    n = 0;
    while (tx_q.size() < FRAME_BYTES && n < WAIT_MAX) begin
      @(negedge clk_125m);
      n++;
    end
    if (tx_q.size() < FRAME_BYTES) begin
      report_timeout("collecting a response frame");
      st  = 'x;
      res = 'x;
    end else begin
      st        = tx_q.pop_front();  // status first
      res[15:8] = tx_q.pop_front();
      res[7:0]  = tx_q.pop_front();
    end
  endtask

  task automatic run_cmd(input string what, input logic [7:0] op, arg, dat,
                         input logic [7:0] exp_st, input logic [15:0] exp_res);
    logic [7:0]  st;
    logic [15:0] res;
    grant_tx(FRAME_BYTES);
    send_frame(op, arg, dat);
    recv_frame(st, res);
    check_rsp(what, st, res, exp_st, exp_res);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_cnt == test_err) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, err_cnt - test_err);
      tests_bad++;
    end
    test_err = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_write_read();
    logic [7:0] addr [4];
    logic [7:0] val  [4];
    addr = '{8'd3, 8'd17, 8'd42, 8'd60};
    for (int i = 0; i < 4; i++) begin
      data_state = lcg_next(data_state);
      val[i]     = data_state[23:16];
      run_cmd("write", OP_WRITE, addr[i], val[i], OP_WRITE, {8'hFF, val[i]});
    end
    for (int i = 0; i < 4; i++) begin
      run_cmd("read", OP_READ, addr[i], 8'h00, OP_READ, {8'h00, val[i]});
    end
    finish_test("write_read");
  endtask

  task automatic test_convert();
    logic [7:0] ch [3];
    ch = '{8'd0, 8'd5, 8'd63};
    for (int i = 0; i < 3; i++) begin
      run_cmd("convert", OP_CONVERT, ch[i], 8'h00, OP_CONVERT,
              16'h8000 + 16'(ch[i]) * 16'd257);
    end
    finish_test("convert");
  endtask

  task automatic test_errors();
    int words0;
    words0 = cs_words;
    run_cmd("unknown opcode", 8'h5A, 8'h01, 8'h00, 8'h5A | 8'h80, 16'h0000);
    run_cmd("read address 64", OP_READ, 8'd64, 8'h00, 8'(OP_READ) | 8'h80, 16'h0000);
    check_count("spi words for bad commands", cs_words, words0);
    finish_test("errors");
  endtask

  task automatic test_backpressure();
    logic [7:0]  st;
    logic [15:0] res;
    int          cred0;
    int          words0;
    int          n;
    words0 = cs_words;
    // third frame sits in the parser once the pipeline is full
    send_frame(OP_CONVERT, 8'd10, 8'h00);
    send_frame(OP_CONVERT, 8'd20, 8'h00);
    send_frame(OP_READ, 8'(ID_REG), 8'h00);
    cred0 = rx_cred_total;
    // wait until both converts have sent their three words
    n = 0;
    while (!(cs_words == words0 + 6 && cs_n) && n < WAIT_MAX) begin
      @(negedge clk_125m);
      n++;
    end
    if (!(cs_words == words0 + 6 && cs_n)) report_timeout("filling the response pipeline");
    repeat (8) @(negedge clk_125m);  // controller settles in S_RESP
    check_count("tx bytes without credit", tx_q.size(), 0);
    check_count("sender credits left", rx_avail, 0);
    check_count("rx credits while stalled", rx_cred_total - cred0, 0);
    grant_tx(3 * FRAME_BYTES);
    recv_frame(st, res);
    check_rsp("held convert 10", st, res, OP_CONVERT, 16'h8000 + 16'd10 * 16'd257);
    recv_frame(st, res);
    check_rsp("held convert 20", st, res, OP_CONVERT, 16'h8000 + 16'd20 * 16'd257);
    recv_frame(st, res);
    check_rsp("held id read", st, res, OP_READ, 16'h0001);
    finish_test("backpressure");
  endtask

  task automatic test_rx_credits();
    int cred0;
    check_count("credits after reset", init_credits, FRAME_BYTES);
    cred0 = rx_cred_total;
    run_cmd("convert 1", OP_CONVERT, 8'd1, 8'h00, OP_CONVERT, 16'h8000 + 16'd257);
    check_count("credits per frame", rx_cred_total - cred0, FRAME_BYTES);
    check_count("total credits", rx_cred_total, FRAME_BYTES + FRAME_BYTES * frames_sent);
    check_count("sender window", rx_avail, FRAME_BYTES);
    finish_test("rx_credits");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    clk_125m      = 1'b0;
    arst_n        = 1'b0;
    rx            = '0;
    tx_credit     = 1'b0;
    gap_state     = SEED;
    data_state    = SEED;
    rx_avail      = 0;
    rx_cred_total = 0;
    tx_budget     = 0;
    frames_sent   = 0;
    err_cnt       = 0;
    test_err      = 0;
    tests_run     = 0;
    tests_bad     = 0;
    repeat (5) @(posedge clk_125m);
    arst_n <= 1'b1;

    n = 0;
    while (rx_cred_total < FRAME_BYTES && n < WAIT_MAX) begin
      @(negedge clk_125m);
      n++;
    end
    if (rx_cred_total < FRAME_BYTES) report_timeout("initial rx credits");
    repeat (8) @(negedge clk_125m);  // let any extra pulse show up
    init_credits = rx_cred_total;

    test_write_read();
    test_convert();
    test_errors();
    test_backpressure();
    test_rx_credits();

    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             tests_run, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
